/* src/chipdma_pkg.sv */
// chip DMA shared definitions: register map, bus structs, DMACON layout and slot timing
package chipdma_pkg;

  // ----------------------------------------
  // register word addresses, bits 8..1 of the byte address
  localparam logic [7:0] REG_DMACONR = 8'h01;  // dma control readback
  localparam logic [7:0] REG_DSKPTH  = 8'h10;  // disk pointer, bits 19..16
  localparam logic [7:0] REG_DSKPTL  = 8'h11;  // disk pointer, bits 15..0
  localparam logic [7:0] REG_FILPTH  = 8'h28;  // fill pointer high
  localparam logic [7:0] REG_FILPTL  = 8'h29;  // fill pointer low
  localparam logic [7:0] REG_FILDAT  = 8'h2A;  // constant fill word
  localparam logic [7:0] REG_FILLEN  = 8'h2B;  // word count, write starts the fill
  localparam logic [7:0] REG_DMACON  = 8'h4B;  // set/clear control write
  localparam logic [7:0] REG_SPRPTH  = 8'h90;  // sprite pointer high
  localparam logic [7:0] REG_SPRPTL  = 8'h91;  // sprite pointer low
  localparam logic [7:0] REG_NONE    = 8'hFF;  // idle register bus

  // ----------------------------------------
  // bus structs
  typedef struct packed {
    logic [8:0] hpos;  // horizontal beam position
    logic [8:0] vpos;  // line number
  } beam_t;

  typedef struct packed {
    logic [19:0] addr;      // chip word address
    logic [7:0]  reg_addr;  // register the fetched word goes to
    logic        we;        // memory write cycle
    logic [15:0] wdata;     // write data
  } dma_bus_t;

  typedef struct packed {
    logic [7:0]  reg_addr;  // REG_NONE when the cpu is not on the register bus
    logic        wr;        // write strobe
    logic [15:0] data;      // cpu data word
  } cpu_reg_t;

  // DMACON as the cpu writes it, bit 15 selects set or clear
  typedef struct packed {
    logic       setclr;    // 1 sets, 0 clears the named bits
    logic [4:0] reserved;
    logic       master;    // bit 9
    logic [1:0] unused;
    logic       fil;       // bit 6
    logic       spr;       // bit 5
    logic       dsk;       // bit 4
    logic [3:0] spare;
  } dmacon_fields_t;

  typedef union packed {
    logic [15:0]    raw;     // plain data view
    dmacon_fields_t fields;  // set/clear view
  } dmacon_word_u;

  localparam logic [15:0] DMACON_MASK = 16'h03FF;  // bits held by the control register

  typedef struct packed {
    logic dsk;
    logic spr;
    logic fil;
  } dma_en_t;  // already and-ed with master

  // ----------------------------------------
  // slot timing, indexed by hpos
  localparam logic [1:0] SLOT_DISK     = 2'd3;          // hpos[1:0] of the disk slot
  localparam logic [1:0] SLOT_SPR      = 2'd1;          // hpos[1:0] of the sprite slot
  localparam logic [7:0] REFRESH_SLOTS = 8'b1010_1010;  // bit n set: hpos n is refresh
  localparam logic [8:0] SPR_FIRST     = 9'd16;         // sprite window opens here
  localparam int         SPR_WORDS     = 4;             // sprite words per line

endpackage

/* src/beam_counter.sv */
// beam counter: horizontal and vertical position with start-of-line and start-of-frame pulses
module beam_counter
#(
  parameter int H_TOTAL = 64,  // cycles per line
  parameter int V_TOTAL = 8    // lines per frame
)
(
  input  logic               clk,
  input  logic               reset,
  output chipdma_pkg::beam_t beam,
  output logic               sol,   // high during the last cycle of a line
  output logic               sof    // high during the last cycle of a frame
);

  logic last_col;   // hpos at end of line
  logic last_line;  // vpos at end of frame

  assign last_col  = beam.hpos == 9'(H_TOTAL - 1);
  assign last_line = beam.vpos == 9'(V_TOTAL - 1);

  // ----------------------------------------
  // position counters
  always_ff @(posedge clk)
  begin
    if (reset)
      beam <= '0;
    else if (last_col)
    begin
      beam.hpos <= '0;                              // wrap to next line
      beam.vpos <= last_line ? '0 : beam.vpos + 9'd1;
    end
    else
      beam.hpos <= beam.hpos + 9'd1;
  end

  // pulses lead the new line/frame by one cycle
  assign sol = last_col;
  assign sof = last_col && last_line;

  // line length never exceeds the configured total
  hpos_in_range: assert property (@(posedge clk) disable iff (reset)
    beam.hpos < 9'(H_TOTAL));

endmodule

/* src/dma_control_regs.sv */
// DMA control register: DMACON set/clear write, DMACONR readback, gated channel enables
module dma_control_regs
(
  input  logic                  clk,
  input  logic                  reset,
  input  chipdma_pkg::cpu_reg_t cpu,
  input  logic                  fill_busy,  // fill engine still has words to write
  output chipdma_pkg::dma_en_t  en,
  output logic [15:0]           rdata       // zero unless DMACONR is addressed
);

  chipdma_pkg::dmacon_word_u wr_word;  // incoming cpu word
  chipdma_pkg::dmacon_word_u dmacon;   // held control bits
  logic [15:0]               wr_mask;  // bits named by the write
  logic                      dmacon_wr;

  assign wr_word   = cpu.data;
  assign wr_mask   = wr_word.raw & chipdma_pkg::DMACON_MASK;  // setclr bit never stored
  assign dmacon_wr = cpu.wr && cpu.reg_addr == chipdma_pkg::REG_DMACON;

  // ----------------------------------------
  // set/clear write
  always_ff @(posedge clk)
  begin
    if (reset)
      dmacon <= '0;                        // all channels off
    else if (dmacon_wr)
    begin
      if (wr_word.fields.setclr)
        dmacon.raw <= dmacon.raw | wr_mask;   // set named bits
      else
        dmacon.raw <= dmacon.raw & ~wr_mask;  // clear named bits
    end
  end

  // channel enables only count while master is on
  assign en.dsk = dmacon.fields.dsk & dmacon.fields.master;
  assign en.spr = dmacon.fields.spr & dmacon.fields.master;
  assign en.fil = dmacon.fields.fil & dmacon.fields.master;

  // ----------------------------------------
  // readback, busy flag sits in bit 14
  always_comb
  begin
    if (cpu.reg_addr == chipdma_pkg::REG_DMACONR)
      rdata = {1'b0, fill_busy, 4'b0000, dmacon.raw[9:0]};
    else
      rdata = 16'h0000;  // or-able onto a shared read bus
  end

endmodule

/* src/disk_dma.sv */
// disk DMA: disk pointer register and fixed-slot transfer engine
module disk_dma
(
  input  logic                  clk,
  input  logic                  reset,
  input  chipdma_pkg::cpu_reg_t cpu,
  input  chipdma_pkg::beam_t    beam,
  input  logic                  disk_req,  // word ready from the disk controller
  input  logic                  enable,
  output logic                  dma,       // disk owns the bus this cycle
  output chipdma_pkg::dma_bus_t bus
);

  localparam logic [15:0] DSK_WORD = 16'hD15C;  // word written by each disk transfer

  logic [19:0] ptr;  // next chip word to write
  logic        pth_wr;
  logic        ptl_wr;

  assign pth_wr = cpu.wr && cpu.reg_addr == chipdma_pkg::REG_DSKPTH;
  assign ptl_wr = cpu.wr && cpu.reg_addr == chipdma_pkg::REG_DSKPTL;

  // fixed slot, nothing above disk so no ack needed
  assign dma = enable && disk_req && beam.hpos[1:0] == chipdma_pkg::SLOT_DISK;

  // ----------------------------------------
  // pointer, cpu load wins over increment
  always_ff @(posedge clk)
  begin
    if (reset)
      ptr <= '0;
    else if (pth_wr)
      ptr[19:16] <= cpu.data[3:0];  // only 4 high bits exist
    else if (ptl_wr)
      ptr[15:0] <= cpu.data;
    else if (dma)
      ptr <= ptr + 20'd1;            // one word per transfer
  end

  // disk cycles are memory writes with no register target
  always_comb
  begin
    bus.addr     = ptr;
    bus.reg_addr = chipdma_pkg::REG_NONE;
    bus.we       = 1'b1;
    bus.wdata    = DSK_WORD;
  end

endmodule

/* src/sprite_dma.sv */
// sprite DMA: sprite pointer register and per-line fetch burst over request/acknowledge
module sprite_dma
(
  input  logic                  clk,
  input  logic                  reset,
  input  chipdma_pkg::cpu_reg_t cpu,
  input  chipdma_pkg::beam_t    beam,
  input  logic                  sof,     // reload working pointer
  input  logic                  enable,
  output logic                  req,
  input  logic                  ack,
  output chipdma_pkg::dma_bus_t bus
);

  localparam int CNT_W = $clog2(chipdma_pkg::SPR_WORDS + 1);

  logic [19:0]      spr_pt;     // cpu loaded base pointer
  logic [19:0]      fetch_pt;   // working pointer, walks through the frame
  logic [CNT_W-1:0] word_cnt;   // words fetched on this line
  logic             in_window;  // sprite slot inside the fetch window
  logic             xfer;

  assign in_window = beam.hpos >= chipdma_pkg::SPR_FIRST &&
                     beam.hpos[1:0] == chipdma_pkg::SLOT_SPR;
  assign req  = enable && in_window && word_cnt != CNT_W'(chipdma_pkg::SPR_WORDS);
  assign xfer = req && ack;  // one word moved

  // ----------------------------------------
  // cpu pointer register
  always_ff @(posedge clk)
  begin
    if (reset)
      spr_pt <= '0;
    else if (cpu.wr && cpu.reg_addr == chipdma_pkg::REG_SPRPTH)
      spr_pt[19:16] <= cpu.data[3:0];
    else if (cpu.wr && cpu.reg_addr == chipdma_pkg::REG_SPRPTL)
      spr_pt[15:0] <= cpu.data;
  end

  // working pointer and line count
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      fetch_pt <= '0;
      word_cnt <= '0;
    end
    else
    begin
      if (sof)
        fetch_pt <= spr_pt;               // restart at top of frame
      else if (xfer)
        fetch_pt <= fetch_pt + 20'd1;
      if (beam.hpos < chipdma_pkg::SPR_FIRST)
        word_cnt <= '0;                   // rearm before the window
      else if (xfer)
        word_cnt <= word_cnt + 1'b1;
    end
  end

  always_comb
  begin
    bus.addr     = fetch_pt;
    bus.reg_addr = chipdma_pkg::REG_SPRPTL;  // sprite data register target
    bus.we       = 1'b0;                     // reads only
    bus.wdata    = 16'h0000;
  end

endmodule

/* src/fill_dma.sv */
// block-fill DMA: writes a constant word over a range and pulses a done interrupt
module fill_dma
(
  input  logic                  clk,
  input  logic                  reset,
  input  chipdma_pkg::cpu_reg_t cpu,
  input  logic                  enable,
  output logic                  req,
  input  logic                  ack,
  output logic                  busy,      // words still to write
  output logic                  int_fill,  // one cycle after the last word
  output chipdma_pkg::dma_bus_t bus
);

  logic [19:0] fil_pt;     // next word to write
  logic [15:0] fil_dat;    // constant fill word
  logic [15:0] remaining;  // words left
  logic        xfer;       // word moved this cycle
  logic        last_word;
  logic        len_wr;

  assign len_wr    = cpu.wr && cpu.reg_addr == chipdma_pkg::REG_FILLEN;
  assign busy      = remaining != 16'd0;
  assign req       = busy && enable;       // held until acked
  assign xfer      = req && ack;
  assign last_word = xfer && remaining == 16'd1;

  // ----------------------------------------
  // pointer, cpu load has priority
  always_ff @(posedge clk)
  begin
    if (reset)
      fil_pt <= '0;
    else if (cpu.wr && cpu.reg_addr == chipdma_pkg::REG_FILPTH)
      fil_pt[19:16] <= cpu.data[3:0];
    else if (cpu.wr && cpu.reg_addr == chipdma_pkg::REG_FILPTL)
      fil_pt[15:0] <= cpu.data;
    else if (xfer)
      fil_pt <= fil_pt + 20'd1;
  end

  always_ff @(posedge clk)
  begin
    if (cpu.wr && cpu.reg_addr == chipdma_pkg::REG_FILDAT)
      fil_dat <= cpu.data;
  end

  // ----------------------------------------
  // word count and done pulse
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      remaining <= '0;
      int_fill  <= 1'b0;
    end
    else
    begin
      int_fill <= last_word;
      if (len_wr)
        remaining <= cpu.data;           // first req next cycle
      else if (xfer)
        remaining <= remaining - 16'd1;
    end
  end

  always_comb
  begin
    bus.addr     = fil_pt;
    bus.reg_addr = chipdma_pkg::REG_NONE;
    bus.we       = 1'b1;
    bus.wdata    = fil_dat;
  end

  // the arbiter only grants a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (reset) ack |-> req);

endmodule

/* src/slot_arbiter.sv */
// slot arbiter: fixed-priority chip bus mux with the fill slowdown counter
module slot_arbiter
#(
  parameter int BLS_CNT_MAX = 3  // denied cycles before fill is locked out
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  chipdma_pkg::beam_t    beam,
  input  chipdma_pkg::cpu_reg_t cpu,
  input  logic                  bls,      // cpu wants the bus back
  input  logic                  dma_dsk,  // disk has taken its slot
  input  chipdma_pkg::dma_bus_t dsk_bus,
  input  logic                  spr_req,
  input  chipdma_pkg::dma_bus_t spr_bus,
  input  logic                  fil_req,
  input  chipdma_pkg::dma_bus_t fil_bus,
  output logic                  spr_ack,
  output logic                  fil_ack,
  output chipdma_pkg::dma_bus_t out_bus,
  output logic                  dbr       // chipset owns the bus
);

  localparam int BLS_W = (BLS_CNT_MAX < 1) ? 1 : $clog2(BLS_CNT_MAX + 1);

  logic [BLS_W-1:0] bls_cnt;     // denied fill cycles while bls holds
  logic             dma_ref;     // refresh slot
  logic             fil_block;   // slowdown limit reached
  logic             fil_denied;

  // refresh takes the odd cycles at the start of each line
  assign dma_ref   = beam.hpos < 9'd8 && chipdma_pkg::REFRESH_SLOTS[beam.hpos[2:0]];
  assign fil_block = bls_cnt == BLS_W'(BLS_CNT_MAX);

  // ----------------------------------------
  // priority mux, first match wins
  always_comb
  begin
    spr_ack = 1'b0;
    fil_ack = 1'b0;
    dbr     = 1'b1;
    out_bus = '0;
    if (dma_dsk)
      out_bus = dsk_bus;                            // disk overrides everything
    else if (dma_ref)
      out_bus.reg_addr = chipdma_pkg::REG_NONE;     // address 0, no target
    else if (spr_req)
    begin
      spr_ack = 1'b1;
      out_bus = spr_bus;
    end
    else if (fil_req && !fil_block)
    begin
      fil_ack = 1'b1;
      out_bus = fil_bus;
    end
    else
    begin
      dbr              = 1'b0;                      // bus free for the cpu
      out_bus.reg_addr = cpu.reg_addr;              // cpu register access passes
    end
  end

  // ----------------------------------------
  // slowdown counter
  assign fil_denied = fil_req && !fil_ack;

  always_ff @(posedge clk)
  begin
    if (reset)
      bls_cnt <= '0;
    else if (!bls)
      bls_cnt <= '0;                     // cpu satisfied, release fill
    else if (fil_denied && !fil_block)
      bls_cnt <= bls_cnt + 1'b1;         // saturates at the limit
  end

  // sprite and fill never share a cycle
  one_ack: assert property (@(posedge clk) disable iff (reset) !(spr_ack && fil_ack));

endmodule

/* src/chipdma_top.sv */
// chip DMA controller top: cpu register bus decode and block interconnect
module chipdma_top
#(
  parameter int H_TOTAL     = 64,
  parameter int V_TOTAL     = 8,
  parameter int BLS_CNT_MAX = 3
)
(
  input  logic        clk,
  input  logic        reset,
  input  logic        aen,              // register bank select
  input  logic        rd,
  input  logic        wr,
  input  logic [7:0]  address_in,       // register word address
  input  logic [15:0] data_in,
  input  logic        disk_req,
  input  logic        bls,
  output logic [15:0] data_out,
  output logic [19:0] address_out,      // chip word address
  output logic [7:0]  reg_address_out,
  output logic        dbr,
  output logic        dbwe,
  output logic [15:0] dma_wdata,
  output logic        sol,
  output logic        sof,
  output logic        int_fill
);

  chipdma_pkg::cpu_reg_t cpu;
  chipdma_pkg::beam_t    beam;
  chipdma_pkg::dma_en_t  en;
  chipdma_pkg::dma_bus_t dsk_bus;
  chipdma_pkg::dma_bus_t spr_bus;
  chipdma_pkg::dma_bus_t fil_bus;
  chipdma_pkg::dma_bus_t out_bus;
  logic                  dma_dsk;
  logic                  spr_req;
  logic                  spr_ack;
  logic                  fil_req;
  logic                  fil_ack;
  logic                  fil_busy;

  // cpu decode, idle bus reads as REG_NONE
  assign cpu.reg_addr = (aen && (rd || wr)) ? address_in : chipdma_pkg::REG_NONE;
  assign cpu.wr       = aen && wr;
  assign cpu.data     = data_in;

  beam_counter #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) u_beam
    (.clk(clk), .reset(reset), .beam(beam), .sol(sol), .sof(sof));

  dma_control_regs u_ctrl
    (.clk(clk), .reset(reset), .cpu(cpu), .fill_busy(fil_busy), .en(en), .rdata(data_out));

  disk_dma u_dsk
    (.clk(clk), .reset(reset), .cpu(cpu), .beam(beam), .disk_req(disk_req),
     .enable(en.dsk), .dma(dma_dsk), .bus(dsk_bus));

  sprite_dma u_spr
    (.clk(clk), .reset(reset), .cpu(cpu), .beam(beam), .sof(sof), .enable(en.spr),
     .req(spr_req), .ack(spr_ack), .bus(spr_bus));

  fill_dma u_fil
    (.clk(clk), .reset(reset), .cpu(cpu), .enable(en.fil), .req(fil_req), .ack(fil_ack),
     .busy(fil_busy), .int_fill(int_fill), .bus(fil_bus));

  slot_arbiter #(.BLS_CNT_MAX(BLS_CNT_MAX)) u_arb
    (.clk(clk), .reset(reset), .beam(beam), .cpu(cpu), .bls(bls), .dma_dsk(dma_dsk),
     .dsk_bus(dsk_bus), .spr_req(spr_req), .spr_bus(spr_bus), .fil_req(fil_req),
     .fil_bus(fil_bus), .spr_ack(spr_ack), .fil_ack(fil_ack), .out_bus(out_bus), .dbr(dbr));

  // granted owner onto the pins
  assign address_out     = out_bus.addr;
  assign reg_address_out = out_bus.reg_addr;
  assign dbwe            = out_bus.we;
  assign dma_wdata       = out_bus.wdata;

endmodule

/* bench/chipdma_tb.sv */
// chip DMA testbench: table-driven register steps checked against a cycle-by-cycle bus model
module chipdma_tb;

  localparam int H_TOTAL     = 64;
  localparam int V_TOTAL     = 8;
  localparam int BLS_CNT_MAX = 3;

  localparam logic [1:0] OP_WR   = 2'd0;  // register write
  localparam logic [1:0] OP_RD   = 2'd1;  // register read, compared with expected
  localparam logic [1:0] OP_WAIT = 2'd2;  // addr 0 waits for int_fill, addr 1 for sof
  localparam logic [1:0] OP_HOLD = 2'd3;  // idle, data[0] random disk_req, data[1] bls

  typedef struct packed {
    logic [1:0]  op;
    logic [7:0]  addr;
    logic [15:0] data;
    logic [15:0] expected;
    logic [15:0] count;     // cycles for hold, cycle limit for wait
  } step_t;

  logic        clk;
  logic        reset;
  logic        aen;
  logic        rd;
  logic        wr;
  logic [7:0]  address_in;
  logic [15:0] data_in;
  logic        disk_req;
  logic        bls;
  logic [15:0] data_out;
  logic [19:0] address_out;
  logic [7:0]  reg_address_out;
  logic        dbr;
  logic        dbwe;
  logic [15:0] dma_wdata;
  logic        sol;
  logic        sof;
  logic        int_fill;

  logic        rand_disk;   // sticky input modes, set by hold steps
  logic        bls_level;
  int          seed = 31473;
  int          rnd;

  // bus model state, values for the current cycle
  int          hpos_m;
  int          vpos_m;
  int          spr_cnt_m;
  int          bls_cnt_m;
  logic [19:0] dsk_ptr_m;
  logic [19:0] spr_base_m;
  logic [19:0] spr_ptr_m;
  logic [19:0] fil_ptr_m;
  logic [15:0] fil_dat_m;
  logic [15:0] fil_rem_m;
  logic [15:0] dmacon_m;
  logic        int_exp;

  int          errors = 0;
  int          checked = 0;
  int          cycles = 0;
  int          limit = 0;    // zero until the table is built
  int          dsk_seen = 0;
  int          spr_seen = 0;
  int          fil_seen = 0;
  int          int_seen = 0;
  int          reloads = 0;
  step_t       rows[$];

  chipdma_top #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .BLS_CNT_MAX(BLS_CNT_MAX)) DUT
    (.clk(clk), .reset(reset), .aen(aen), .rd(rd), .wr(wr), .address_in(address_in),
     .data_in(data_in), .disk_req(disk_req), .bls(bls), .data_out(data_out),
     .address_out(address_out), .reg_address_out(reg_address_out), .dbr(dbr), .dbwe(dbwe),
     .dma_wdata(dma_wdata), .sol(sol), .sof(sof), .int_fill(int_fill));

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ----------------------------------------
  // helpers
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("error %s got %h expected %h at hpos %0d", name, got, exp, hpos_m);
  endtask

  function automatic string op_name(input logic [1:0] op);
    case (op)
      OP_WR:   op_name = "write";
      OP_RD:   op_name = "read";
      OP_WAIT: op_name = "wait";
      default: op_name = "hold";
    endcase
  endfunction

  task automatic add_step(input logic [1:0] op, input logic [7:0] addr,
                          input logic [15:0] data, input logic [15:0] expected,
                          input logic [15:0] count);
    rows.push_back('{op, addr, data, expected, count});
  endtask

  // one clock later, bus idle, sticky inputs reapplied
  task automatic next_cycle;
    @(posedge clk);
    #1;
    aen        = 1'b0;
    rd         = 1'b0;
    wr         = 1'b0;
    address_in = 8'h00;
    data_in    = 16'h0000;
    rnd        = $random(seed);
    disk_req   = rand_disk & rnd[0];
    bls        = bls_level;
  endtask

  task automatic run_step(input step_t s);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    case (s.op)
      OP_WR:
      begin
        next_cycle();
        aen        = 1'b1;
        wr         = 1'b1;
        address_in = s.addr;
        data_in    = s.data;
      end
      OP_RD:
      begin
        next_cycle();
        aen        = 1'b1;
        rd         = 1'b1;
        address_in = s.addr;
        @(negedge clk);
        if (data_out !== s.expected)
          report_mismatch("data_out", data_out, s.expected);
      end
      OP_WAIT:
      begin
        while (!seen && waited < s.count)
        begin
          next_cycle();
          @(negedge clk);
          seen = (s.addr == 8'd0) ? int_fill : sof;
          waited++;
        end
        if (!seen)
        begin
          errors++;
          $display("%s did not pulse within %0d cycles",
                   (s.addr == 8'd0) ? "int_fill" : "sof", s.count);
        end
      end
      default:
      begin
        rand_disk = s.data[0];
        bls_level = s.data[1];
        repeat (s.count) next_cycle();
      end
    endcase
  endtask

  // ----------------------------------------
  // bus monitor, priority rule per cycle
  always @(negedge clk)
  begin : bus_monitor
    logic        en_dsk;
    logic        en_spr;
    logic        en_fil;
    logic        fil_req;
    logic        own_dsk;
    logic        own_ref;
    logic        own_spr;
    logic        own_fil;
    logic        blk;
    logic        exp_dbr;
    logic        exp_we;
    logic        exp_sol;
    logic        exp_sof;
    logic        cpu_wr;
    logic [7:0]  cpu_reg;
    logic [7:0]  exp_reg;
    logic [15:0] mask;
    logic [15:0] exp_wdata;
    logic [19:0] exp_addr;
    if (reset)
    begin
      hpos_m     = 0;
      vpos_m     = 0;
      spr_cnt_m  = 0;
      bls_cnt_m  = 0;
      dsk_ptr_m  = '0;
      spr_base_m = '0;
      spr_ptr_m  = '0;
      fil_ptr_m  = '0;
      fil_rem_m  = '0;
      dmacon_m   = '0;
      int_exp    = 1'b0;
    end
    else
    begin
      en_dsk  = dmacon_m[9] && dmacon_m[4];         // channel bits gated by master
      en_spr  = dmacon_m[9] && dmacon_m[5];
      en_fil  = dmacon_m[9] && dmacon_m[6];
      cpu_wr  = aen && wr;
      cpu_reg = (aen && (rd || wr)) ? address_in : 8'hFF;
      blk     = bls_cnt_m == BLS_CNT_MAX;
      fil_req = en_fil && fil_rem_m != 16'd0;
      own_dsk = en_dsk && disk_req && hpos_m % 4 == 3;
      own_ref = !own_dsk && hpos_m < 8 && hpos_m % 2 == 1;
      own_spr = !own_dsk && !own_ref && en_spr && hpos_m >= 16 && hpos_m % 4 == 1 &&
                spr_cnt_m < 4;                      // four words per line
      own_fil = !own_dsk && !own_ref && !own_spr && fil_req && !blk;
      exp_dbr   = own_dsk || own_ref || own_spr || own_fil;
      exp_we    = own_dsk || own_fil;
      exp_sol   = hpos_m == H_TOTAL - 1;
      exp_sof   = exp_sol && vpos_m == V_TOTAL - 1;
      exp_addr  = 20'h0;
      exp_reg   = cpu_reg;                          // free bus passes the cpu through
      exp_wdata = 16'h0;
      if (own_dsk)
      begin
        exp_addr  = dsk_ptr_m;
        exp_reg   = 8'hFF;
        exp_wdata = 16'hD15C;
      end
      else if (own_ref)
        exp_reg = 8'hFF;
      else if (own_spr)
      begin
        exp_addr = spr_ptr_m;
        exp_reg  = 8'h91;                           // sprite data target
      end
      else if (own_fil)
      begin
        exp_addr  = fil_ptr_m;
        exp_reg   = 8'hFF;
        exp_wdata = fil_dat_m;
      end

      if (dbr !== exp_dbr)
        report_mismatch("dbr", dbr, exp_dbr);
      if (address_out !== exp_addr)
        report_mismatch("address_out", address_out, exp_addr);
      if (reg_address_out !== exp_reg)
        report_mismatch("reg_address_out", reg_address_out, exp_reg);
      if (dbwe !== exp_we)
        report_mismatch("dbwe", dbwe, exp_we);
      if (dma_wdata !== exp_wdata)
        report_mismatch("dma_wdata", dma_wdata, exp_wdata);
      if (int_fill !== int_exp)
        report_mismatch("int_fill", int_fill, int_exp);
      if (sol !== exp_sol)
        report_mismatch("sol", sol, exp_sol);
      if (sof !== exp_sof)
        report_mismatch("sof", sof, exp_sof);
      checked++;
      if (int_fill === 1'b1)
        int_seen++;

      // next cycle's model state
      int_exp = own_fil && fil_rem_m == 16'd1;     // pulse follows the last word
      if (own_dsk)
      begin
        dsk_ptr_m = dsk_ptr_m + 20'd1;
        dsk_seen++;
      end
      if (own_spr)
      begin
        spr_ptr_m = spr_ptr_m + 20'd1;
        spr_cnt_m++;
        spr_seen++;
      end
      if (own_fil)
      begin
        fil_ptr_m = fil_ptr_m + 20'd1;
        fil_rem_m = fil_rem_m - 16'd1;
        fil_seen++;
      end
      if (hpos_m < 16)
        spr_cnt_m = 0;                              // rearmed before the window
      if (exp_sof)
      begin
        spr_ptr_m = spr_base_m;                     // frame restart
        reloads++;
      end
      if (!bls)
        bls_cnt_m = 0;
      else if (fil_req && !own_fil && !blk)
        bls_cnt_m++;

      // cpu writes land at the coming edge, loads beat increments
      if (cpu_wr)
      begin
        mask = data_in & 16'h03FF;
        case (cpu_reg)
          chipdma_pkg::REG_DSKPTH: dsk_ptr_m[19:16] = data_in[3:0];
          chipdma_pkg::REG_DSKPTL: dsk_ptr_m[15:0]  = data_in;
          chipdma_pkg::REG_SPRPTH: spr_base_m[19:16] = data_in[3:0];
          chipdma_pkg::REG_SPRPTL: spr_base_m[15:0]  = data_in;
          chipdma_pkg::REG_FILPTH: fil_ptr_m[19:16] = data_in[3:0];
          chipdma_pkg::REG_FILPTL: fil_ptr_m[15:0]  = data_in;
          chipdma_pkg::REG_FILDAT: fil_dat_m = data_in;
          chipdma_pkg::REG_FILLEN: fil_rem_m = data_in;
          chipdma_pkg::REG_DMACON:
            dmacon_m = data_in[15] ? (dmacon_m | mask) : (dmacon_m & ~mask);
          default: ;
        endcase
      end

      if (hpos_m == H_TOTAL - 1)
      begin
        hpos_m = 0;
        vpos_m = (vpos_m == V_TOTAL - 1) ? 0 : vpos_m + 1;
      end
      else
        hpos_m = hpos_m + 1;
    end
  end

  // ----------------------------------------
  // run limit
  always @(posedge clk)
  begin
    cycles++;
    if (limit > 0 && cycles > limit)
    begin
      $display("timeout after %0d cycles, a step never finished", limit);
      $display("** FAIL **");
      $finish;
    end
  end

  initial
  begin : main_seq
    int total;
    reset      = 1'b1;
    aen        = 1'b0;
    rd         = 1'b0;
    wr         = 1'b0;
    address_in = 8'h00;
    data_in    = 16'h0000;
    disk_req   = 1'b0;
    bls        = 1'b0;
    rand_disk  = 1'b0;
    bls_level  = 1'b0;
    fil_dat_m  = 16'h0000;

    // pointers and fill word
    add_step(OP_WR, chipdma_pkg::REG_DSKPTH, 16'h0001, 16'h0, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_DSKPTL, 16'h2000, 16'h0, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_SPRPTH, 16'h0002, 16'h0, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_SPRPTL, 16'h0100, 16'h0, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_FILPTH, 16'h0003, 16'h0, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_FILPTL, 16'h0400, 16'h0, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_FILDAT, 16'hA5A5, 16'h0, 16'd1);
    // DMACON set and clear
    add_step(OP_RD, chipdma_pkg::REG_DMACONR, 16'h0, 16'h0000, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_DMACON, 16'h8230, 16'h0, 16'd1);  // master, spr, dsk
    add_step(OP_RD, chipdma_pkg::REG_DMACONR, 16'h0, 16'h0230, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_DMACON, 16'h0010, 16'h0, 16'd1);  // clear dsk
    add_step(OP_RD, chipdma_pkg::REG_DMACONR, 16'h0, 16'h0220, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_DMACON, 16'h8010, 16'h0, 16'd1);
    add_step(OP_RD, chipdma_pkg::REG_DMACONR, 16'h0, 16'h0230, 16'd1);
    // more than a frame of disk, refresh and sprite traffic
    add_step(OP_HOLD, 8'h00, 16'h0001, 16'h0, 16'd600);
    add_step(OP_HOLD, 8'h00, 16'h0000, 16'h0, 16'd1);
    // plain fill of 16 words
    add_step(OP_WR, chipdma_pkg::REG_DMACON, 16'h8040, 16'h0, 16'd1);
    add_step(OP_RD, chipdma_pkg::REG_DMACONR, 16'h0, 16'h0270, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_FILLEN, 16'h0010, 16'h0, 16'd1);
    add_step(OP_RD, chipdma_pkg::REG_DMACONR, 16'h0, 16'h4270, 16'd1);
    add_step(OP_WAIT, 8'h00, 16'h0, 16'h0, 16'd200);
    add_step(OP_RD, chipdma_pkg::REG_DMACONR, 16'h0, 16'h0270, 16'd1);
    // fill of 64 words with bls held high
    add_step(OP_HOLD, 8'h00, 16'h0002, 16'h0, 16'd1);
    add_step(OP_WR, chipdma_pkg::REG_FILLEN, 16'h0040, 16'h0, 16'd1);
    add_step(OP_HOLD, 8'h00, 16'h0002, 16'h0, 16'd200);
    add_step(OP_RD, chipdma_pkg::REG_DMACONR, 16'h0, 16'h4270, 16'd1);  // locked, still busy
    add_step(OP_HOLD, 8'h00, 16'h0000, 16'h0, 16'd1);
    add_step(OP_WAIT, 8'h00, 16'h0, 16'h0, 16'd300);
    add_step(OP_RD, chipdma_pkg::REG_DMACONR, 16'h0, 16'h0270, 16'd1);
    add_step(OP_WAIT, 8'h01, 16'h0, 16'h0, 16'd600);

    total = 0;
    foreach (rows[i])
      total += rows[i].count;
    limit = total * H_TOTAL + 200;

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    foreach (rows[i])
    begin
      run_step(rows[i]);
      $display("step %0d %s %h done, errors %0d", i, op_name(rows[i].op), rows[i].addr, errors);
    end
    repeat (4) next_cycle();

    // traffic that must have happened at all
    if (dsk_seen == 0)
    begin
      errors++;
      $display("no disk transfer was seen");
    end
    if (spr_seen == 0 || reloads == 0)
    begin
      errors++;
      $display("sprite fetches or the frame reload never happened");
    end
    if (fil_seen != 80)
    begin
      errors++;
      $display("fill moved %0d words instead of 80", fil_seen);
    end
    if (int_seen != 2)
    begin
      errors++;
      $display("int_fill pulsed %0d times instead of 2", int_seen);
    end

    $display("steps %0d, cycles checked %0d, errors %0d", rows.size(), checked, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* chipdma.f */
src/chipdma_pkg.sv
src/beam_counter.sv
src/dma_control_regs.sv
src/disk_dma.sv
src/sprite_dma.sv
src/fill_dma.sv
src/slot_arbiter.sv
src/chipdma_top.sv
bench/chipdma_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the chip DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module chipdma_tb \
  -Mdir obj_dir -f chipdma.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vchipdma_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  exit 1
fi
exit 0
